//--- verif/pulse_meas_vectors.txt
# one session per line: pulse value (12 bit hex), switch word (18 bit hex),
# pulse width (6 bit hex, push lasts width+1 cycles)
a5c 2b3c7 03
fff 3ffff 00
001 00000 3f
7e4 1a55a 0c
3c3 25aa5 1f

//--- src.f
+incdir+verilog
verilog/link_pkg.sv
verilog/meas_pkg.sv
verilog/host_cmd_decoder.sv
verilog/sample_capture.sv
verilog/sample_uplink.sv
verilog/session_sequencer.sv
verilog/pulse_meas_top.sv
verif/tb_pulse_meas.sv

//--- Makefile
SIM      := verilator
FLAGS    := --timing --assert
TOP      := tb_pulse_meas
FILELIST := src.f
OBJDIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- verif/tb_pulse_meas.sv
// pulse measurement controller testbench
// runs one session per vector line and checks switch bank, dac push and uplink bytes
`timescale 1ns/1ps
`include "meas_defs.svh"

module tb_pulse_meas;
    import link_pkg::*;
    import meas_pkg::*;

    logic         clk;
    logic         reset;
    logic         credit_return;
    link_byte_t   rx_byte;
    adc_sample_t  adc_in;
    link_byte_t   tx_byte;
    dac_cmd_t     dac_cmd;
    switch_bank_t switch_out;

    int                   cycle;
    int                   outstanding;         // bytes sent but not yet credited back
    int                   credit_due[$];       // cycle at which each credit goes back
    bit                   hold_credits;
    bit                   adc_on;
    logic [7:0]           tx_seen[$];
    logic [`SAMPLE_W-1:0] sent_samples[$];

    pulse_meas_top u_pulse_meas_top (
        .clk           (clk),
        .reset         (reset),
        .credit_return (credit_return),
        .rx_byte       (rx_byte),
        .adc_in        (adc_in),
        .tx_byte       (tx_byte),
        .dac_cmd       (dac_cmd),
        .switch_out    (switch_out)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic abort(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    // one clock: observe outputs just after the edge, then drive the next inputs
    task automatic tick();
        logic [31:0] rnd;
        @(posedge clk);
        #2;
        cycle++;
        if (tx_byte.valid) begin
            tx_seen.push_back(tx_byte.data);
            outstanding++;
            assert (outstanding <= `LINK_CREDITS) else begin
                abort("uplink sent a byte without a credit");
            end
            credit_due.push_back(cycle + int'($urandom_range(5, 0)));
        end
        credit_return = 1'b0;
        if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            credit_return = 1'b1;
            outstanding--;
        end
        rx_byte = '0;
        adc_in  = '0;
        if (adc_on && sent_samples.size() < `SAMPLE_COUNT && $urandom_range(3, 0) != 0) begin
            rnd          = $urandom();
            adc_in.valid = 1'b1;
            adc_in.data  = rnd[`SAMPLE_W-1:0];
            sent_samples.push_back(rnd[`SAMPLE_W-1:0]);
        end
    endtask

    task automatic send_byte(input logic [1:0] tag, input logic [5:0] payload);
        rx_byte.valid                 = 1'b1;
        rx_byte.data.cmd_view.tag     = tag;
        rx_byte.data.cmd_view.payload = payload;
        tick();
    endtask

    task automatic wait_push(input string what);
        int waited;
        waited = 0;
        while (!dac_cmd.push) begin
            if (waited == 200)
                abort({"timeout waiting for dac push ", what});
            tick();
            waited++;
        end
    endtask

    task automatic next_tx_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        while (tx_seen.size() == 0) begin
            // stalled on zero credits long enough, let the host catch up
            if (hold_credits && outstanding == `LINK_CREDITS && waited >= 20)
                hold_credits = 1'b0;
            if (waited == 400)
                abort("timeout waiting for an uplink byte");
            tick();
            waited++;
        end
        b = tx_seen.pop_front();
    endtask

    task automatic run_session(input int index, input logic [`PULSE_W-1:0] pulse,
                               input logic [`SWITCH_W-1:0] sw,
                               input logic [`WIDTH_W-1:0] width);
        switch_bank_t         exp_bank;
        logic [7:0]           lo_byte;
        logic [7:0]           hi_byte;
        logic [7:0]           exp_lo;
        logic [7:0]           exp_hi;
        logic [`SAMPLE_W-1:0] s;
        int                   push_cycles;
        exp_bank.main_reset = sw[16];
        exp_bank.main_rw    = sw[17];
        exp_bank.single     = sw[7:0];
        exp_bank.pair_a     = sw[15:8];
        exp_bank.pair_b     = ~sw[15:8];
        if (index % 2 == 0) begin           // low half first
            send_byte(2'b01, pulse[5:0]);
            send_byte(2'b10, pulse[11:6]);
        end else begin
            send_byte(2'b11, pulse[11:6]);
            send_byte(2'b00, pulse[5:0]);
        end
        // each switch part and the width preceded by a wrong tag
        send_byte(2'b01, ~sw[5:0]);
        send_byte(2'b10, sw[5:0]);
        send_byte(2'b11, ~sw[11:6]);
        send_byte(2'b01, sw[11:6]);
        send_byte(2'b00, ~sw[17:12]);
        send_byte(2'b10, sw[17:12]);
        send_byte(2'b10, ~width);
        send_byte(2'b01, width);

        wait_push("for the pulse");
        check_value("switch bank", 32'(exp_bank), 32'(switch_out));
        check_value("pair complement", 32'hff, 32'(switch_out.pair_a ^ switch_out.pair_b));
        push_cycles = 0;
        while (dac_cmd.push) begin
            check_value("dac value", 32'(pulse), 32'(dac_cmd.value));
            push_cycles++;
            if (push_cycles > 100)
                abort("dac push never ended");
            tick();
        end
        check_value("push length", 32'(width) + 1, 32'(push_cycles));
        adc_on       = 1'b1;                 // capture armed from here
        hold_credits = (index % 2 == 1);

        for (int k = 0; k < `SAMPLE_COUNT; k++) begin
            next_tx_byte(lo_byte);
            next_tx_byte(hi_byte);
            s      = sent_samples[k];
            exp_lo = {3'b000, s[4:0]};
            exp_hi = {3'b111, s[9:5]};
            check_value("uplink low byte", 32'(exp_lo), 32'(lo_byte));
            check_value("uplink high byte", 32'(exp_hi), 32'(hi_byte));
            repeat ($urandom_range(3, 0)) begin
                tick();
                check_value("byte before ack", 0, 32'(tx_seen.size()));
            end
            send_byte(2'b01, 6'h15);        // not an ack here
            check_value("byte before ack", 0, 32'(tx_seen.size()));
            send_byte(2'b10, 6'h00);
        end

        wait_push("for the clear");
        check_value("clear dac value", 0, 32'(dac_cmd.value));
        check_value("byte after last ack", 0, 32'(tx_seen.size()));
        tick();
        adc_on = 1'b0;
        sent_samples.delete();
        repeat (`CLEAR_CYCLES + `START_DELAY) begin
            check_value("single clear push", 0, 32'(dac_cmd.push));
            check_value("bank held through clear", 32'(exp_bank), 32'(switch_out));
            check_value("tx idle after session", 0, 32'(tx_byte.valid));
            tick();
        end
    endtask

    initial begin
        int                   fd;
        int                   sessions;
        string                line;
        logic [`PULSE_W-1:0]  pulse;
        logic [`SWITCH_W-1:0] sw;
        logic [`WIDTH_W-1:0]  width;
        void'($urandom(32'hb04f_2a87));
        clk           = 1'b0;
        reset         = 1'b1;
        credit_return = 1'b0;
        rx_byte       = '0;
        adc_in        = '0;
        cycle         = 0;
        outstanding   = 0;
        hold_credits  = 1'b0;
        adc_on        = 1'b0;
        sessions      = 0;
        repeat (8) tick();
        check_value("bank after reset", 0, 32'(switch_out));
        check_value("push after reset", 0, 32'(dac_cmd.push));
        check_value("dac value after reset", 0, 32'(dac_cmd.value));
        check_value("tx valid after reset", 0, 32'(tx_byte.valid));
        reset = 1'b0;
        repeat (`START_DELAY + 2) tick();   // past the start delay

        fd = $fopen("verif/pulse_meas_vectors.txt", "r");
        if (fd == 0)
            abort("cannot open the vector file");
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %h", pulse, sw, width) == 3) begin
                run_session(sessions, pulse, sw, width);
                sessions++;
            end
        end
        $fclose(fd);

        if (sessions == 0) begin
            abort("the vector file holds no sessions");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- verilog/pulse_meas_top.sv
// pulse measurement controller top level
// decoder and capture feed the sequencer and the uplink
`timescale 1ns/1ps
`include "meas_defs.svh"

module pulse_meas_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   credit_return,
    input  link_pkg::link_byte_t   rx_byte,
    input  meas_pkg::adc_sample_t  adc_in,
    output link_pkg::link_byte_t   tx_byte,
    output meas_pkg::dac_cmd_t     dac_cmd,
    output meas_pkg::switch_bank_t switch_out
);
    import meas_pkg::*;

    session_phase_t                    phase;
    logic                              load_done;
    logic                              ack_seen;
    logic [`PULSE_W-1:0]               pulse_value;
    logic [`SWITCH_W-1:0]              switch_word;
    logic [`WIDTH_W-1:0]               pulse_width;
    logic                              capture_arm;
    logic                              capture_full;
    logic                              uplink_start;
    logic                              uplink_done;
    logic [$clog2(`SAMPLE_COUNT)-1:0]  rd_index;
    logic [`SAMPLE_W-1:0]              rd_data;

    host_cmd_decoder u_host_cmd_decoder (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .rx_byte     (rx_byte),
        .load_done   (load_done),
        .ack_seen    (ack_seen),
        .pulse_value (pulse_value),
        .switch_word (switch_word),
        .pulse_width (pulse_width)
    );

    sample_capture u_sample_capture (
        .clk      (clk),
        .reset    (reset),
        .arm      (capture_arm),
        .adc_in   (adc_in),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .full     (capture_full)
    );

    sample_uplink u_sample_uplink (
        .clk           (clk),
        .reset         (reset),
        .start         (uplink_start),
        .ack_seen      (ack_seen),
        .credit_return (credit_return),
        .rd_index      (rd_index),
        .rd_data       (rd_data),
        .tx_byte       (tx_byte),
        .done          (uplink_done)
    );

    session_sequencer u_session_sequencer (
        .clk          (clk),
        .reset        (reset),
        .load_done    (load_done),
        .capture_full (capture_full),
        .uplink_done  (uplink_done),
        .pulse_value  (pulse_value),
        .switch_word  (switch_word),
        .pulse_width  (pulse_width),
        .phase        (phase),
        .capture_arm  (capture_arm),
        .uplink_start (uplink_start),
        .dac_cmd      (dac_cmd),
        .switch_out   (switch_out)
    );

endmodule

//--- verilog/session_sequencer.sv
// session sequencer
// steps the session phases, drives the switch bank and the dac command
`timescale 1ns/1ps
`include "meas_defs.svh"

module session_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load_done,
    input  logic                     capture_full,
    input  logic                     uplink_done,
    input  logic [`PULSE_W-1:0]      pulse_value,
    input  logic [`SWITCH_W-1:0]     switch_word,
    input  logic [`WIDTH_W-1:0]      pulse_width,
    output meas_pkg::session_phase_t phase,
    output logic                     capture_arm,
    output logic                     uplink_start,
    output meas_pkg::dac_cmd_t       dac_cmd,
    output meas_pkg::switch_bank_t   switch_out
);
    import meas_pkg::*;

    localparam int CNT_W = 8;   // covers the longest timed phase

    session_phase_t   phase_next;
    logic [CNT_W-1:0] cycle_cnt;     // cycles spent in current phase
    logic [7:0]       pair_bits;

    always_comb begin
        phase_next = phase;
        case (phase)
            START:
                if (cycle_cnt == CNT_W'(`START_DELAY - 1))
                    phase_next = LOAD_PULSE;
            LOAD_PULSE:
                if (load_done)
                    phase_next = LOAD_SWITCH;
            LOAD_SWITCH:
                if (load_done)
                    phase_next = LOAD_WIDTH;
            LOAD_WIDTH:
                if (load_done)
                    phase_next = SETTLE;
            SETTLE:
                if (cycle_cnt == CNT_W'(`SETTLE_CYCLES - 1))
                    phase_next = DAC_PUSH;
            DAC_PUSH:
                if (cycle_cnt == CNT_W'(pulse_width))   // width+1 cycles of push
                    phase_next = CAPTURE;
            CAPTURE:
                if (capture_full)
                    phase_next = UPLINK;
            UPLINK:
                if (uplink_done)
                    phase_next = CLEAR;
            default:
                if (cycle_cnt == CNT_W'(`CLEAR_CYCLES - 1))
                    phase_next = START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= START;
            cycle_cnt    <= '0;
            uplink_start <= 1'b0;
        end else begin
            phase        <= phase_next;
            uplink_start <= (phase == CAPTURE) && capture_full;  // first cycle of UPLINK
            if (phase_next != phase)
                cycle_cnt <= '0;
            else
                cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    assign pair_bits = switch_word[15:8];

    // bank latched on entry to SETTLE and held through the clear
    always_ff @(posedge clk) begin
        if (reset) begin
            switch_out <= '0;
        end else if (phase == SETTLE && cycle_cnt == '0) begin
            switch_out.main_reset <= switch_word[16];
            switch_out.main_rw    <= switch_word[17];
            switch_out.single     <= switch_word[7:0];
            switch_out.pair_a     <= pair_bits;
            switch_out.pair_b     <= ~pair_bits;   // complementary side of each pair
        end
    end

    assign capture_arm = (phase == CAPTURE);

    // clear sends a single zero push to park the dac
    assign dac_cmd.push  = (phase == DAC_PUSH) || (phase == CLEAR && cycle_cnt == '0);
    assign dac_cmd.value = (phase == DAC_PUSH) ? pulse_value : '0;

endmodule

//--- verilog/sample_uplink.sv
// sample uplink
// sends each stored sample as two tagged bytes under credit control
// then waits for the host acknowledge
`timescale 1ns/1ps
`include "meas_defs.svh"

module sample_uplink (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic                              ack_seen,
    input  logic                              credit_return,
    output logic [$clog2(`SAMPLE_COUNT)-1:0]  rd_index,
    input  logic [`SAMPLE_W-1:0]              rd_data,
    output link_pkg::link_byte_t              tx_byte,
    output logic                              done
);
    import link_pkg::*;

    localparam int IDX_W    = $clog2(`SAMPLE_COUNT);
    localparam int CREDIT_W = $clog2(`LINK_CREDITS + 1);

    typedef enum logic [1:0] {
        UL_IDLE,
        UL_SEND_LO,
        UL_SEND_HI,
        UL_WAIT_ACK
    } uplink_state_t;

    uplink_state_t       state;
    logic [CREDIT_W-1:0] credit_cnt;
    logic                send;

    assign send = (state == UL_SEND_LO || state == UL_SEND_HI) && credit_cnt != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= UL_IDLE;
            rd_index   <= '0;
            credit_cnt <= CREDIT_W'(`LINK_CREDITS);
            tx_byte    <= '0;
            done       <= 1'b0;
        end else begin
            credit_cnt    <= credit_cnt - CREDIT_W'(send) + CREDIT_W'(credit_return);
            tx_byte.valid <= send;
            done          <= 1'b0;
            case (state)
                UL_IDLE: if (start) begin
                    rd_index <= '0;
                    state    <= UL_SEND_LO;
                end
                UL_SEND_LO: if (send) begin     // holds here with no credit
                    tx_byte.data.sample_view.tag  <= TAG_SAMPLE_LO;
                    tx_byte.data.sample_view.half <= rd_data[4:0];
                    state <= UL_SEND_HI;
                end
                UL_SEND_HI: if (send) begin
                    tx_byte.data.sample_view.tag  <= TAG_SAMPLE_HI;
                    tx_byte.data.sample_view.half <= rd_data[9:5];
                    state <= UL_WAIT_ACK;
                end
                default: if (ack_seen) begin
                    if (rd_index == IDX_W'(`SAMPLE_COUNT - 1)) begin
                        done  <= 1'b1;          // block finished
                        state <= UL_IDLE;
                    end else begin
                        rd_index <= rd_index + 1'b1;
                        state    <= UL_SEND_LO;
                    end
                end
            endcase
        end
    end

    // count above the bound means an extra credit return or a send on zero credit
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= CREDIT_W'(`LINK_CREDITS));

endmodule

//--- verilog/sample_capture.sv
// adc sample capture
// stores one block of samples while armed, read back by index
`timescale 1ns/1ps
`include "meas_defs.svh"

module sample_capture (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              arm,
    input  meas_pkg::adc_sample_t             adc_in,
    input  logic [$clog2(`SAMPLE_COUNT)-1:0]  rd_index,
    output logic [`SAMPLE_W-1:0]              rd_data,
    output logic                              full
);
    localparam int IDX_W = $clog2(`SAMPLE_COUNT);

    logic [`SAMPLE_W-1:0] mem [`SAMPLE_COUNT];
    logic [IDX_W-1:0]     wr_index;
    logic                 write_en;

    assign write_en = arm && adc_in.valid && !full;

    always_ff @(posedge clk) begin
        if (reset || !arm) begin     // index restarts once capture is released
            wr_index <= '0;
            full     <= 1'b0;
        end else if (write_en) begin
            wr_index <= wr_index + 1'b1;
            if (wr_index == IDX_W'(`SAMPLE_COUNT - 1))
                full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en)
            mem[wr_index] <= adc_in.data;
    end

    assign rd_data = mem[rd_index];   // uplink reads without latency

    // sequencer drops arm right after the block fills, so no sample lands on a full block
    a_release_after_full: assert property (@(posedge clk) disable iff (reset)
        $rose(full) |=> !arm);

endmodule

//--- verilog/host_cmd_decoder.sv
// host command decoder
// takes inbound bytes by phase and holds the session settings
`timescale 1ns/1ps
`include "meas_defs.svh"

module host_cmd_decoder (
    input  logic                     clk,
    input  logic                     reset,
    input  meas_pkg::session_phase_t phase,
    input  link_pkg::link_byte_t     rx_byte,
    output logic                     load_done,
    output logic                     ack_seen,
    output logic [`PULSE_W-1:0]      pulse_value,
    output logic [`SWITCH_W-1:0]     switch_word,
    output logic [`WIDTH_W-1:0]      pulse_width
);
    import meas_pkg::*;
    import link_pkg::*;

    logic [1:0] tag;
    logic [5:0] payload;
    logic [1:0] pulse_got;      // bit 0 low half, bit 1 high half
    logic [1:0] switch_part;    // next switch part expected
    logic       take_pulse_lo;
    logic       take_pulse_hi;
    logic       take_switch;
    logic       take_width;

    assign tag     = rx_byte.data.cmd_view.tag;
    assign payload = rx_byte.data.cmd_view.payload;

    // halves may come in either order
    assign take_pulse_lo = rx_byte.valid && phase == LOAD_PULSE && !tag[1];
    assign take_pulse_hi = rx_byte.valid && phase == LOAD_PULSE && tag[1];
    assign take_switch   = rx_byte.valid && phase == LOAD_SWITCH
                           && tag == ((switch_part == 2'd1) ? TAG_SWITCH_MID : TAG_SWITCH_EDGE);
    assign take_width    = rx_byte.valid && phase == LOAD_WIDTH && tag == TAG_WIDTH;

    assign load_done = (take_pulse_lo && pulse_got[1])
                    || (take_pulse_hi && pulse_got[0])
                    || (take_switch && switch_part == 2'd2)   // last of three parts
                    || take_width;

    assign ack_seen = rx_byte.valid && phase == UPLINK && tag == TAG_ACK;

    always_ff @(posedge clk) begin
        if (reset || phase == CLEAR) begin   // session end wipes settings
            pulse_value <= '0;
            switch_word <= '0;
            pulse_width <= '0;
            pulse_got   <= '0;
            switch_part <= '0;
        end else begin
            if (take_pulse_lo) begin
                pulse_value[5:0] <= payload;
                pulse_got[0]     <= 1'b1;
            end
            if (take_pulse_hi) begin
                pulse_value[11:6] <= payload;
                pulse_got[1]      <= 1'b1;
            end
            if (take_switch) begin
                case (switch_part)
                    2'd0:    switch_word[5:0]   <= payload;
                    2'd1:    switch_word[11:6]  <= payload;
                    default: switch_word[17:12] <= payload;
                endcase
                switch_part <= switch_part + 2'd1;
            end
            if (take_width)
                pulse_width <= payload;
        end
    end

    // a completed load must move the sequencer on the next cycle
    a_load_done_in_load: assert property (@(posedge clk) disable iff (reset)
        load_done |-> (phase inside {LOAD_PULSE, LOAD_SWITCH, LOAD_WIDTH})
                      ##1 (phase != $past(phase)));

endmodule

//--- verilog/meas_pkg.sv
// measurement side types
// switch bank, dac command, adc sample and session phase
`include "meas_defs.svh"

package meas_pkg;

    // pairs run sw9, sw10, vt1..vt3, hz1..hz3 from bit 0 up
    typedef struct packed {
        logic       main_reset;
        logic       main_rw;
        logic [7:0] single;     // switches 1 to 8
        logic [7:0] pair_a;
        logic [7:0] pair_b;     // complement of pair_a
    } switch_bank_t;

    typedef struct packed {
        logic                push;
        logic [`PULSE_W-1:0] value;
    } dac_cmd_t;

    typedef struct packed {
        logic                 valid;
        logic [`SAMPLE_W-1:0] data;
    } adc_sample_t;

    typedef enum logic [3:0] {
        START,
        LOAD_PULSE,
        LOAD_SWITCH,
        LOAD_WIDTH,
        SETTLE,
        DAC_PUSH,
        CAPTURE,
        UPLINK,
        CLEAR
    } session_phase_t;

endpackage

//--- verilog/link_pkg.sv
// host byte link types
// one byte seen as a command on the way in and as a sample half on the way out
package link_pkg;

    typedef struct packed {
        logic [1:0] tag;
        logic [5:0] payload;
    } cmd_view_t;

    typedef struct packed {
        logic [2:0] tag;
        logic [4:0] half;      // five bits of a sample
    } sample_view_t;

    typedef union packed {
        cmd_view_t    cmd_view;
        sample_view_t sample_view;
    } host_byte_u;

    typedef struct packed {
        logic       valid;
        host_byte_u data;
    } link_byte_t;

    // inbound tags
    localparam logic [1:0] TAG_SWITCH_EDGE = 2'b10;   // switch parts one and three
    localparam logic [1:0] TAG_SWITCH_MID  = 2'b01;
    localparam logic [1:0] TAG_WIDTH       = 2'b01;
    localparam logic [1:0] TAG_ACK         = 2'b10;

    // outbound tags
    localparam logic [2:0] TAG_SAMPLE_LO   = 3'b000;
    localparam logic [2:0] TAG_SAMPLE_HI   = 3'b111;

endpackage

//--- verilog/meas_defs.svh
// pulse measurement controller sizes and timing
// counts are in clock cycles
`ifndef MEAS_DEFS_SVH
`define MEAS_DEFS_SVH

// block sizes
`define SAMPLE_COUNT   32      // adc samples per session
`define SAMPLE_W       10      // adc sample width
`define PULSE_W        12      // dac value width
`define SWITCH_W       18      // host switch word
`define WIDTH_W        6       // pulse width field

// session timing
`define START_DELAY    8       // idle before loading starts
`define SETTLE_CYCLES  16      // switch apply to dac push
`define CLEAR_CYCLES   8       // length of clear phase

// uplink flow control
`define LINK_CREDITS   4       // bytes in flight toward the host

`endif
